/* source/dram_pkg.sv */
package dram_pkg;

    // DDR4 bus widths
    localparam int ADDR_W = 17;
    localparam int BG_W   = 2;
    localparam int BA_W   = 2;
    localparam int MR_W   = 14;

    // A10 selects long calibration in a ZQ command
    localparam int ZQ_LONG_BIT = 10;

    typedef enum logic [3:0] {
        POWER_UP,
        PRE_RESET,
        RESET,
        NOP,
        LOAD_MODE_DLL,
        LOAD_BG0_REG3,
        LOAD_BG1_REG6,
        LOAD_BG1_REG5,
        LOAD_BG1_REG4,
        LOAD_BG0_REG2,
        LOAD_BG0_REG1,
        LOAD_BG0_REG0,
        ZQ_CL,
        IDLE
    } dram_state_t;

    typedef enum logic [3:0] {
        CMD_DES,
        CMD_NOP,
        CMD_MRS,
        CMD_ZQCL
    } dram_cmd_t;

    // pin order is cs_n, act_n, ras_n, cas_n, we_n
    localparam logic [4:0] CMD_PINS_DES  = 5'b11111;
    localparam logic [4:0] CMD_PINS_NOP  = 5'b01111;
    localparam logic [4:0] CMD_PINS_MRS  = 5'b01000;
    localparam logic [4:0] CMD_PINS_ZQCL = 5'b01110;

    function automatic logic [4:0] cmd_pins(input dram_cmd_t cmd);
        case (cmd)
            CMD_NOP:  return CMD_PINS_NOP;
            CMD_MRS:  return CMD_PINS_MRS;
            CMD_ZQCL: return CMD_PINS_ZQCL;
            default:  return CMD_PINS_DES;
        endcase
    endfunction

endpackage

/* source/timing_counter.sv */
`timescale 1ns/1ps

module timing_counter #(
    parameter int NBITS = 12
) (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             clear,
    input  logic             count_enable,
    input  logic [NBITS-1:0] overflow_val,
    output logic [NBITS-1:0] count_out,
    output logic             overflow_flag
);

    // clear wins over enable
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            count_out <= '0;
        end else if (clear) begin
            count_out <= '0;
        end else if (count_enable) begin
            count_out <= count_out + 1'b1;
        end
    end

    // high for as long as the count sits on the target
    assign overflow_flag = (count_out == overflow_val);

endmodule

/* source/init_state.sv */
`timescale 1ns/1ps

module init_state import dram_pkg::*; #(
    parameter int               CNT_W    = 12,
    parameter logic [CNT_W-1:0] T_PWUP   = 'd4000,
    parameter logic [CNT_W-1:0] T_RESET  = 'd800,
    parameter logic [CNT_W-1:0] T_XPR    = 'd216,
    parameter logic [CNT_W-1:0] T_DLLK   = 'd768,
    parameter logic [CNT_W-1:0] T_MOD    = 'd24,
    parameter logic [CNT_W-1:0] T_ZQINIT = 'd1024
) (
    input  logic        CLK,
    input  logic        nRST,
    input  logic        init,
    output dram_state_t state,
    output logic        init_valid
);

    dram_state_t      n_state;
    dram_state_t      step_state;
    logic [CNT_W-1:0] timing_value;
    logic             timing_clear;
    logic             timing_flag;
    logic             timing_cnt_en;
    logic             n_timing_cnt_en;
    logic             n_init_valid;

    timing_counter #(
        .NBITS(CNT_W)
    ) wait_counter (
        .CLK          (CLK),
        .nRST         (nRST),
        .clear        (timing_clear),
        .count_enable (timing_cnt_en),
        .overflow_val (timing_value),
        .count_out    (),
        .overflow_flag(timing_flag)
    );

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state         <= POWER_UP;
            timing_cnt_en <= 1'b0;
            init_valid    <= 1'b0;
        end else begin
            state         <= n_state;
            timing_cnt_en <= n_timing_cnt_en;
            init_valid    <= n_init_valid;
        end
    end

    // wait length and successor of each state
    always_comb begin
        timing_value = '0;
        step_state   = state;
        case (state)
            POWER_UP: begin
                timing_value = T_PWUP;
                step_state   = PRE_RESET;
            end
            PRE_RESET: begin
                timing_value = T_RESET;
                step_state   = RESET;
            end
            RESET: begin
                timing_value = T_PWUP;
                step_state   = NOP;
            end
            NOP: begin
                timing_value = T_XPR;
                step_state   = LOAD_MODE_DLL;
            end
            LOAD_MODE_DLL: begin
                timing_value = T_DLLK;
                step_state   = LOAD_BG0_REG3;
            end
            LOAD_BG0_REG3: begin
                timing_value = T_MOD;
                step_state   = LOAD_BG1_REG6;
            end
            LOAD_BG1_REG6: begin
                timing_value = T_MOD;
                step_state   = LOAD_BG1_REG5;
            end
            LOAD_BG1_REG5: begin
                timing_value = T_MOD;
                step_state   = LOAD_BG1_REG4;
            end
            LOAD_BG1_REG4: begin
                timing_value = T_MOD;
                step_state   = LOAD_BG0_REG2;
            end
            LOAD_BG0_REG2: begin
                timing_value = T_MOD;
                step_state   = LOAD_BG0_REG1;
            end
            LOAD_BG0_REG1: begin
                timing_value = T_MOD;
                step_state   = LOAD_BG0_REG0;
            end
            LOAD_BG0_REG0: begin
                timing_value = T_MOD;
                step_state   = ZQ_CL;
            end
            ZQ_CL: begin
                timing_value = T_ZQINIT;
                step_state   = IDLE;
            end
            default: begin
                step_state = IDLE;
            end
        endcase
    end

    always_comb begin
        n_state         = state;
        n_timing_cnt_en = timing_cnt_en;
        n_init_valid    = init_valid;
        timing_clear    = 1'b0;

        // init only counts while still powering up
        if (state == POWER_UP && init) begin
            n_timing_cnt_en = 1'b1;
        end

        if (timing_flag && state != IDLE) begin
            timing_clear = 1'b1;
            n_state      = step_state;
            if (state == ZQ_CL) begin
                n_init_valid    = 1'b1;
                n_timing_cnt_en = 1'b0;
            end
        end
    end

endmodule

/* source/init_cmd_gen.sv */
`timescale 1ns/1ps

module init_cmd_gen import dram_pkg::*; #(
    parameter logic [MR_W-1:0] MR0_VAL = 14'h0a50,
    parameter logic [MR_W-1:0] MR1_VAL = 14'h0101,
    parameter logic [MR_W-1:0] MR2_VAL = 14'h0018,
    parameter logic [MR_W-1:0] MR3_VAL = 14'h0000,
    parameter logic [MR_W-1:0] MR4_VAL = 14'h0000,
    parameter logic [MR_W-1:0] MR5_VAL = 14'h0400,
    parameter logic [MR_W-1:0] MR6_VAL = 14'h0800
) (
    input  logic              CLK,
    input  logic              nRST,
    input  dram_state_t       state,
    output logic              reset_n,
    output logic              cke,
    output logic              cs_n,
    output logic              act_n,
    output logic              ras_n,
    output logic              cas_n,
    output logic              we_n,
    output logic [BG_W-1:0]   bg,
    output logic [BA_W-1:0]   ba,
    output logic [ADDR_W-1:0] addr
);

    dram_state_t       prev_state;
    logic              state_entry;
    logic              is_mrs;
    logic [2:0]        mr_num;
    logic [MR_W-1:0]   mr_val;
    dram_cmd_t         n_cmd;
    logic [4:0]        n_pins;
    logic [BG_W-1:0]   n_bg;
    logic [BA_W-1:0]   n_ba;
    logic [ADDR_W-1:0] n_addr;
    logic              n_reset_n;
    logic              n_cke;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            prev_state <= POWER_UP;
        end else begin
            prev_state <= state;
        end
    end

    assign state_entry = (state != prev_state);

    // mode register addressed by each load state
    always_comb begin
        is_mrs = 1'b1;
        case (state)
            LOAD_BG0_REG3: mr_num = 3'd3;
            LOAD_BG1_REG6: mr_num = 3'd6;
            LOAD_BG1_REG5: mr_num = 3'd5;
            LOAD_BG1_REG4: mr_num = 3'd4;
            LOAD_BG0_REG2: mr_num = 3'd2;
            LOAD_BG0_REG1: mr_num = 3'd1;
            LOAD_BG0_REG0: mr_num = 3'd0;
            default: begin
                mr_num = 3'd0;
                is_mrs = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (mr_num)
            3'd1:    mr_val = MR1_VAL;
            3'd2:    mr_val = MR2_VAL;
            3'd3:    mr_val = MR3_VAL;
            3'd4:    mr_val = MR4_VAL;
            3'd5:    mr_val = MR5_VAL;
            3'd6:    mr_val = MR6_VAL;
            default: mr_val = MR0_VAL;
        endcase
    end

    always_comb begin
        n_cmd  = CMD_DES;
        n_bg   = '0;
        n_ba   = '0;
        n_addr = '0;
        if (state_entry && is_mrs) begin
            // bg from bit 2, ba from bits 1:0
            n_cmd  = CMD_MRS;
            n_bg   = BG_W'(mr_num[2]);
            n_ba   = BA_W'(mr_num[1:0]);
            n_addr = ADDR_W'(mr_val);
        end else if (state_entry && state == ZQ_CL) begin
            n_cmd               = CMD_ZQCL;
            n_addr[ZQ_LONG_BIT] = 1'b1;
        end
        n_pins = cmd_pins(n_cmd);
    end

    assign n_reset_n = !(state inside {POWER_UP, PRE_RESET});
    assign n_cke     = !(state inside {POWER_UP, PRE_RESET, RESET});

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            reset_n                         <= 1'b0;
            cke                             <= 1'b0;
            {cs_n, act_n, ras_n, cas_n, we_n} <= CMD_PINS_DES;
            bg                              <= '0;
            ba                              <= '0;
            addr                            <= '0;
        end else begin
            reset_n                         <= n_reset_n;
            cke                             <= n_cke;
            {cs_n, act_n, ras_n, cas_n, we_n} <= n_pins;
            bg                              <= n_bg;
            ba                              <= n_ba;
            addr                            <= n_addr;
        end
    end

endmodule

/* source/dram_init_top.sv */
`timescale 1ns/1ps

module dram_init_top import dram_pkg::*; #(
    parameter int               CNT_W    = 12,
    parameter logic [CNT_W-1:0] T_PWUP   = 'd4000,
    parameter logic [CNT_W-1:0] T_RESET  = 'd800,
    parameter logic [CNT_W-1:0] T_XPR    = 'd216,
    parameter logic [CNT_W-1:0] T_DLLK   = 'd768,
    parameter logic [CNT_W-1:0] T_MOD    = 'd24,
    parameter logic [CNT_W-1:0] T_ZQINIT = 'd1024,
    parameter logic [MR_W-1:0]  MR0_VAL  = 14'h0a50,
    parameter logic [MR_W-1:0]  MR1_VAL  = 14'h0101,
    parameter logic [MR_W-1:0]  MR2_VAL  = 14'h0018,
    parameter logic [MR_W-1:0]  MR3_VAL  = 14'h0000,
    parameter logic [MR_W-1:0]  MR4_VAL  = 14'h0000,
    parameter logic [MR_W-1:0]  MR5_VAL  = 14'h0400,
    parameter logic [MR_W-1:0]  MR6_VAL  = 14'h0800
) (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              init,
    output logic              init_valid,
    output dram_state_t       init_state,
    output logic              reset_n,
    output logic              cke,
    output logic              cs_n,
    output logic              act_n,
    output logic              ras_n,
    output logic              cas_n,
    output logic              we_n,
    output logic [BG_W-1:0]   bg,
    output logic [BA_W-1:0]   ba,
    output logic [ADDR_W-1:0] addr
);

    init_state #(
        .CNT_W   (CNT_W),
        .T_PWUP  (T_PWUP),
        .T_RESET (T_RESET),
        .T_XPR   (T_XPR),
        .T_DLLK  (T_DLLK),
        .T_MOD   (T_MOD),
        .T_ZQINIT(T_ZQINIT)
    ) sequencer (
        .CLK       (CLK),
        .nRST      (nRST),
        .init      (init),
        .state     (init_state),
        .init_valid(init_valid)
    );

    // pins follow the sequencer state one clock later
    init_cmd_gen #(
        .MR0_VAL(MR0_VAL),
        .MR1_VAL(MR1_VAL),
        .MR2_VAL(MR2_VAL),
        .MR3_VAL(MR3_VAL),
        .MR4_VAL(MR4_VAL),
        .MR5_VAL(MR5_VAL),
        .MR6_VAL(MR6_VAL)
    ) cmd_gen (
        .CLK    (CLK),
        .nRST   (nRST),
        .state  (init_state),
        .reset_n(reset_n),
        .cke    (cke),
        .cs_n   (cs_n),
        .act_n  (act_n),
        .ras_n  (ras_n),
        .cas_n  (cas_n),
        .we_n   (we_n),
        .bg     (bg),
        .ba     (ba),
        .addr   (addr)
    );

endmodule

/* verification/tb_dram_init.sv */
`timescale 1ns/1ps

module tb_dram_init import dram_pkg::*; ();

    localparam int CLK_PERIOD = 4;
    localparam int RST_CYCLES = 4;
    localparam int T_PWUP     = 20;
    localparam int T_RESET    = 8;
    localparam int T_XPR      = 10;
    localparam int T_DLLK     = 16;
    localparam int T_MOD      = 6;
    localparam int T_ZQINIT   = 24;
    localparam int MAX_IDLE   = 24;
    localparam int POST_WAIT  = 2 * T_ZQINIT;
    localparam int SEQ_CYCLES = 2 * T_PWUP + T_RESET + T_XPR + T_DLLK + 7 * T_MOD + T_ZQINIT + 16;
    localparam int WATCHDOG_NS =
        3 * (3 * SEQ_CYCLES + 3 * (RST_CYCLES + MAX_IDLE) + POST_WAIT) * CLK_PERIOD;
    localparam logic [31:0]     SEED    = 32'hb25c_e34c;
    localparam logic [MR_W-1:0] MR_BASE = 14'h0100;

    typedef struct packed {
        dram_cmd_t         kind;
        int                cycle;
        logic [BG_W-1:0]   bg;
        logic [BA_W-1:0]   ba;
        logic [ADDR_W-1:0] addr;
    } cmd_rec_t;

    logic              CLK, nRST, init;
    logic              init_valid, reset_n, cke;
    logic              cs_n, act_n, ras_n, cas_n, we_n;
    logic [BG_W-1:0]   bg;
    logic [BA_W-1:0]   ba;
    logic [ADDR_W-1:0] addr;
    dram_state_t       init_state;

    cmd_rec_t cmd_q[$];
    int       cycle;
    int       init_cycle, rst_rise, cke_rise, valid_rise;
    int       errors;
    int       total_cmds;

    dram_init_top #(
        .T_PWUP  (T_PWUP),
        .T_RESET (T_RESET),
        .T_XPR   (T_XPR),
        .T_DLLK  (T_DLLK),
        .T_MOD   (T_MOD),
        .T_ZQINIT(T_ZQINIT),
        .MR0_VAL (MR_BASE + 14'd0),
        .MR1_VAL (MR_BASE + 14'd1),
        .MR2_VAL (MR_BASE + 14'd2),
        .MR3_VAL (MR_BASE + 14'd3),
        .MR4_VAL (MR_BASE + 14'd4),
        .MR5_VAL (MR_BASE + 14'd5),
        .MR6_VAL (MR_BASE + 14'd6)
    ) dut (
        .CLK       (CLK),
        .nRST      (nRST),
        .init      (init),
        .init_valid(init_valid),
        .init_state(init_state),
        .reset_n   (reset_n),
        .cke       (cke),
        .cs_n      (cs_n),
        .act_n     (act_n),
        .ras_n     (ras_n),
        .cas_n     (cas_n),
        .we_n      (we_n),
        .bg        (bg),
        .ba        (ba),
        .addr      (addr)
    );

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    always @(posedge CLK) begin
        cycle <= cycle + 1;
    end

    function automatic logic [MR_W-1:0] expected_mr(input int n);
        return MR_BASE + MR_W'(n);
    endfunction

    task automatic log_error(input string msg);
        errors++;
        $display("** Error at %0t ns: %s", $time, msg);
    endtask

    task automatic clear_records();
        cmd_q.delete();
        init_cycle = -1;
        rst_rise   = -1;
        cke_rise   = -1;
        valid_rise = -1;
    endtask

    // records the first rise of each level and every non-DES command
    always @(negedge CLK) begin
        cmd_rec_t rec;
        if (init && init_cycle < 0) begin
            init_cycle = cycle;
        end
        if (reset_n && rst_rise < 0) begin
            rst_rise = cycle;
        end
        if (cke && cke_rise < 0) begin
            cke_rise = cycle;
        end
        if (init_valid && valid_rise < 0) begin
            valid_rise = cycle;
            assert (init_state == IDLE) else log_error("init_valid rose outside IDLE");
        end
        if (!cs_n) begin
            rec.cycle = cycle;
            rec.bg    = bg;
            rec.ba    = ba;
            rec.addr  = addr;
            case ({cs_n, act_n, ras_n, cas_n, we_n})
                CMD_PINS_MRS:  rec.kind = CMD_MRS;
                CMD_PINS_ZQCL: rec.kind = CMD_ZQCL;
                CMD_PINS_NOP:  rec.kind = CMD_NOP;
                default: begin
                    rec.kind = CMD_DES;
                    log_error("unknown command pin pattern");
                end
            endcase
            cmd_q.push_back(rec);
            total_cmds++;
        end
    end

    a_cke_after_reset: assert property (@(posedge CLK) disable iff (!nRST) cke |-> reset_n)
        else log_error("cke high while reset_n low");
    a_valid_holds: assert property (@(posedge CLK) disable iff (!nRST) init_valid |=> init_valid)
        else log_error("init_valid dropped");
    a_quiet_when_done: assert property (@(posedge CLK) disable iff (!nRST)
        init_valid |-> (init_state == IDLE && cs_n))
        else log_error("command or state change after completion");
    a_one_cycle_cmd: assert property (@(posedge CLK) disable iff (!nRST) !cs_n |=> cs_n)
        else log_error("command held longer than one cycle");

    task automatic check_reset_levels(input string where);
        assert (!init_valid && !reset_n && !cke)
            else log_error({where, ": init_valid, reset_n or cke not low"});
        assert (cs_n && bg == '0 && ba == '0 && addr == '0)
            else log_error({where, ": command bus not DES"});
    endtask

    // caller sits on a rising edge
    task automatic reset_dut();
        nRST <= 1'b0;
        @(negedge CLK);
        check_reset_levels("reset asserted");
        assert (init_state == POWER_UP) else log_error("state not POWER_UP in reset");
        repeat (RST_CYCLES) @(posedge CLK);
        nRST <= 1'b1;
        clear_records();
    endtask

    task automatic idle_before_init();
        int delay;
        delay = $urandom_range(MAX_IDLE, 4);
        repeat (delay) begin
            @(negedge CLK);
            check_reset_levels("idle before init");
        end
    endtask

    task automatic pulse_init();
        @(posedge CLK);
        init <= 1'b1;
        @(posedge CLK);
        init <= 1'b0;
    endtask

    task automatic wait_init_valid();
        do begin
            @(negedge CLK);
        end while (!init_valid);
        @(posedge CLK);
    endtask

    task automatic check_sequence();
        int       order [7] = '{3, 6, 5, 4, 2, 1, 0};
        cmd_rec_t rec;
        assert (cmd_q.size() == 8)
            else log_error($sformatf("expected 7 MRS and 1 ZQCL, saw %0d", cmd_q.size()));
        assert (init_cycle >= 0 && rst_rise - init_cycle >= T_PWUP)
            else log_error("reset_n released too soon after init");
        assert (cke_rise > rst_rise) else log_error("cke did not rise after reset_n");
        if (cmd_q.size() == 8) begin
            assert (cmd_q[0].cycle - cke_rise >= T_XPR + T_DLLK)
                else log_error("first command too soon after cke");
            for (int i = 0; i < 7; i++) begin
                rec = cmd_q[i];
                assert (rec.kind == CMD_MRS && rec.bg == BG_W'(order[i] >> 2)
                        && rec.ba == BA_W'(order[i] & 3)
                        && rec.addr == ADDR_W'(expected_mr(order[i])))
                    else log_error($sformatf("command %0d is not the MR%0d write", i, order[i]));
                assert (cmd_q[i + 1].cycle - rec.cycle >= T_MOD)
                    else log_error($sformatf("command %0d follows too closely", i + 1));
            end
            rec = cmd_q[7];
            assert (rec.kind == CMD_ZQCL && rec.addr[ZQ_LONG_BIT])
                else log_error("last command is not ZQCL with A10 set");
            assert (valid_rise - rec.cycle >= T_ZQINIT)
                else log_error("init_valid rose too soon after ZQCL");
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog: the init sequence never finished within %0d ns", WATCHDOG_NS);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        CLK        = 1'b0;
        nRST       = 1'b0;
        init       = 1'b0;
        cycle      = 0;
        errors     = 0;
        total_cmds = 0;
        void'($urandom(SEED));
        clear_records();
        reset_dut();

        idle_before_init();
        pulse_init();
        wait_init_valid();
        check_sequence();

        // a second init after completion
        pulse_init();
        repeat (POST_WAIT) @(posedge CLK);
        assert (init_valid && cmd_q.size() == 8)
            else log_error("init after completion changed the outputs");

        // reset in the middle of the MRS series
        reset_dut();
        idle_before_init();
        pulse_init();
        while (cmd_q.size() < 3) @(posedge CLK);
        reset_dut();

        idle_before_init();
        pulse_init();
        wait_init_valid();
        check_sequence();

        $display("summary: %0d errors, %0d commands decoded", errors, total_cmds);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
source/dram_pkg.sv
source/timing_counter.sv
source/init_state.sv
source/init_cmd_gen.sv
source/dram_init_top.sv
verification/tb_dram_init.sv
